// File: flist.f
logic/cpuPkg.sv
logic/regFile.sv
logic/alu.sv
logic/opDecoder.sv
logic/sequencer.sv
logic/cpuTop.sv
verif/cpuTb.sv

// File: logic/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic [cpuPkg::dataWidth-1:0] op1,
    input  logic [cpuPkg::dataWidth-1:0] op2,
    input  logic [2:0]                   aluOp,
    input  logic                         wide,
    input  logic [cpuPkg::flagWidth-1:0] flagsIn,
    input  logic [2:0]                   condSel,
    output logic [cpuPkg::dataWidth-1:0] result,
    output logic [cpuPkg::flagWidth-1:0] flagsOut,
    output logic                         condTrue
);

    logic [cpuPkg::dataWidth:0] sum;   // One extra bit for carry out
    logic carryIn;
    logic isSub;
    logic isLogic;
    logic msb1;
    logic msb2;
    logic msbR;

    assign carryIn = flagsIn[cpuPkg::flagCf];

    always_comb begin
        case (aluOp)
            cpuPkg::aluAdd: sum = {1'b0, op1} + {1'b0, op2};
            cpuPkg::aluAdc: sum = {1'b0, op1} + {1'b0, op2} + carryIn;
            cpuPkg::aluSbb: sum = {1'b0, op1} - {1'b0, op2} - carryIn;
            cpuPkg::aluOr:  sum = {1'b0, op1 | op2};
            cpuPkg::aluAnd: sum = {1'b0, op1 & op2};
            cpuPkg::aluXor: sum = {1'b0, op1 ^ op2};
            default:        sum = {1'b0, op1} - {1'b0, op2};   // SUB, CMP
        endcase
    end

    assign result  = sum[cpuPkg::dataWidth-1:0];
    assign isSub   = aluOp == cpuPkg::aluSbb || aluOp == cpuPkg::aluSub ||
                     aluOp == cpuPkg::aluCmp;
    assign isLogic = aluOp == cpuPkg::aluOr || aluOp == cpuPkg::aluAnd ||
                     aluOp == cpuPkg::aluXor;

    // Sign bits at the selected width
    assign msb1 = wide ? op1[15] : op1[7];
    assign msb2 = wide ? op2[15] : op2[7];
    assign msbR = wide ? sum[15] : sum[7];

    // Flags ----------------------------------
    always_comb begin
        flagsOut = flagsIn;   // DF, IF, TF pass through
        flagsOut[1] = 1'b1;
        flagsOut[cpuPkg::flagCf] = !isLogic && (wide ? sum[16] : sum[8]);
        flagsOut[cpuPkg::flagPf] = ~^sum[7:0];
        flagsOut[cpuPkg::flagAf] = !isLogic && (op1[4] ^ op2[4] ^ sum[4]);
        flagsOut[cpuPkg::flagZf] = wide ? (sum[15:0] == '0) : (sum[7:0] == '0);
        flagsOut[cpuPkg::flagSf] = msbR;
        if (isLogic)
            flagsOut[cpuPkg::flagOf] = 1'b0;
        else if (isSub)
            flagsOut[cpuPkg::flagOf] = (msb1 != msb2) && (msbR != msb1);
        else
            flagsOut[cpuPkg::flagOf] = (msb1 == msb2) && (msbR != msb1);
    end

    // Jcc conditions, before the odd-opcode inversion
    always_comb begin
        case (condSel)
            3'd0: condTrue = flagsIn[cpuPkg::flagOf];
            3'd1: condTrue = flagsIn[cpuPkg::flagCf];
            3'd2: condTrue = flagsIn[cpuPkg::flagZf];
            3'd3: condTrue = flagsIn[cpuPkg::flagCf] | flagsIn[cpuPkg::flagZf];
            3'd4: condTrue = flagsIn[cpuPkg::flagSf];
            3'd5: condTrue = flagsIn[cpuPkg::flagPf];
            3'd6: condTrue = flagsIn[cpuPkg::flagSf] ^ flagsIn[cpuPkg::flagOf];
            default: condTrue = (flagsIn[cpuPkg::flagSf] ^ flagsIn[cpuPkg::flagOf]) |
                                flagsIn[cpuPkg::flagZf];
        endcase
    end

endmodule

// File: logic/cpuPkg.sv
package cpuPkg;

    // Widths ------------------------------
    localparam int dataWidth = 16;
    localparam int byteWidth = 8;
    localparam int addrWidth = 16;
    localparam int flagWidth = 12;

    localparam logic [addrWidth-1:0] resetIp    = 16'hFFF0;
    localparam logic [flagWidth-1:0] resetFlags = 12'h002;   // Reserved bit 1 set

    // FLAGS bit positions
    localparam int flagCf = 0;
    localparam int flagPf = 2;
    localparam int flagAf = 4;
    localparam int flagZf = 6;
    localparam int flagSf = 7;
    localparam int flagIf = 9;
    localparam int flagDf = 10;
    localparam int flagOf = 11;

    // ALU ops, same as opcode bits 5:3
    localparam logic [2:0] aluAdd = 3'd0;
    localparam logic [2:0] aluOr  = 3'd1;
    localparam logic [2:0] aluAdc = 3'd2;
    localparam logic [2:0] aluSbb = 3'd3;
    localparam logic [2:0] aluAnd = 3'd4;
    localparam logic [2:0] aluSub = 3'd5;
    localparam logic [2:0] aluXor = 3'd6;
    localparam logic [2:0] aluCmp = 3'd7;

    localparam logic [2:0] regAx = 3'd0;   // AX or AL

    // Sequencer states
    localparam logic [2:0] stFetch = 3'd0;
    localparam logic [2:0] stModrm = 3'd1;
    localparam logic [2:0] stExec  = 3'd2;
    localparam logic [2:0] stMemLo = 3'd3;
    localparam logic [2:0] stMemHi = 3'd4;

    typedef enum logic [2:0] {
        clsAluModrm, clsAluImm, clsMov, clsMovImm, clsJcc, clsJmp8, clsFlag, clsNop
    } opClass;

    // One opcode byte, two decodings
    typedef union packed {
        struct packed {
            logic [1:0] group;
            logic [2:0] aluOp;
            logic       immForm;
            logic       dir;
            logic       wide;
        } aluView;
        struct packed {
            logic [3:0] family;
            logic       wide;
            logic [2:0] regIdx;
        } regView;
    } opcodeWord;

endpackage

// File: logic/cpuTop.sv
`timescale 1ns/1ns

module cpuTop (
    input  logic                         clk25,
    input  logic                         reset,
    input  logic [cpuPkg::byteWidth-1:0] i,
    output logic [cpuPkg::addrWidth-1:0] a,
    output logic [cpuPkg::byteWidth-1:0] o,
    output logic                         w
);

    cpuPkg::opcodeWord            opcode;
    cpuPkg::opClass               cls;
    logic [2:0]                   decAluOp;
    logic                         decDir;
    logic                         decWide;
    logic [2:0]                   decRegIdx;
    logic [2:0]                   rdIdx;
    logic                         rdWide;
    logic [cpuPkg::dataWidth-1:0] rdData;
    logic                         wrEn;
    logic [2:0]                   wrIdx;
    logic                         wrWide;
    logic [cpuPkg::dataWidth-1:0] wrData;
    logic [cpuPkg::dataWidth-1:0] bxVal;
    logic [cpuPkg::dataWidth-1:0] bpVal;
    logic [cpuPkg::dataWidth-1:0] siVal;
    logic [cpuPkg::dataWidth-1:0] diVal;
    logic [cpuPkg::dataWidth-1:0] op1;
    logic [cpuPkg::dataWidth-1:0] op2;
    logic [2:0]                   aluOp;
    logic                         wide;
    logic [cpuPkg::flagWidth-1:0] flags;
    logic [2:0]                   condSel;
    logic [cpuPkg::dataWidth-1:0] result;
    logic [cpuPkg::flagWidth-1:0] flagsOut;
    logic                         condTrue;

    opDecoder i_opDecoder (
        .opcode(opcode), .cls(cls), .aluOp(decAluOp), .dir(decDir),
        .wide(decWide), .regIdx(decRegIdx)
    );

    regFile i_regFile (
        .clk25(clk25), .reset(reset), .rdIdx(rdIdx), .rdWide(rdWide), .rdData(rdData),
        .wrEn(wrEn), .wrIdx(wrIdx), .wrWide(wrWide), .wrData(wrData),
        .bxVal(bxVal), .bpVal(bpVal), .siVal(siVal), .diVal(diVal)
    );

    alu i_alu (
        .op1(op1), .op2(op2), .aluOp(aluOp), .wide(wide), .flagsIn(flags),
        .condSel(condSel), .result(result), .flagsOut(flagsOut), .condTrue(condTrue)
    );

    sequencer i_sequencer (
        .clk25(clk25), .reset(reset), .i(i), .a(a), .o(o), .w(w),
        .opcode(opcode), .cls(cls), .decAluOp(decAluOp), .decDir(decDir),
        .decWide(decWide), .decRegIdx(decRegIdx),
        .rdIdx(rdIdx), .rdWide(rdWide), .rdData(rdData),
        .wrEn(wrEn), .wrIdx(wrIdx), .wrWide(wrWide), .wrData(wrData),
        .bxVal(bxVal), .bpVal(bpVal), .siVal(siVal), .diVal(diVal),
        .op1(op1), .op2(op2), .aluOp(aluOp), .wide(wide), .flags(flags),
        .condSel(condSel), .result(result), .flagsOut(flagsOut), .condTrue(condTrue)
    );

endmodule

// File: logic/opDecoder.sv
`timescale 1ns/1ns

module opDecoder (
    input  cpuPkg::opcodeWord opcode,
    output cpuPkg::opClass    cls,
    output logic [2:0]        aluOp,
    output logic              dir,
    output logic              wide,
    output logic [2:0]        regIdx
);

    always_comb begin
        aluOp  = opcode.aluView.aluOp;
        dir    = opcode.aluView.dir;
        wide   = opcode.aluView.wide;
        regIdx = opcode.regView.regIdx;
        cls    = cpuPkg::clsNop;   // Anything unknown runs as NOP

        if (opcode.aluView.group == 2'b00) begin
            // 00-3F: ModRM forms, or acc,imm when bit 2 is set
            if (!opcode.aluView.immForm) begin
                cls = cpuPkg::clsAluModrm;
            end else if (!opcode.aluView.dir) begin
                cls    = cpuPkg::clsAluImm;
                regIdx = cpuPkg::regAx;
            end
        end else if (opcode.regView.family == 4'hB) begin
            cls  = cpuPkg::clsMovImm;   // B0-BF
            wide = opcode.regView.wide;
        end else if (opcode.regView.family == 4'h7) begin
            cls = cpuPkg::clsJcc;
        end else if (opcode[7:2] == 6'b100010) begin
            cls = cpuPkg::clsMov;       // 88-8B
        end else if (opcode == 8'hEB) begin
            cls = cpuPkg::clsJmp8;
        end else if (opcode == 8'hF5 || (opcode >= 8'hF8 && opcode <= 8'hFD)) begin
            cls = cpuPkg::clsFlag;
        end
    end

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic                         clk25,
    input  logic                         reset,
    input  logic [2:0]                   rdIdx,
    input  logic                         rdWide,
    output logic [cpuPkg::dataWidth-1:0] rdData,
    input  logic                         wrEn,
    input  logic [2:0]                   wrIdx,
    input  logic                         wrWide,
    input  logic [cpuPkg::dataWidth-1:0] wrData,
    output logic [cpuPkg::dataWidth-1:0] bxVal,
    output logic [cpuPkg::dataWidth-1:0] bpVal,
    output logic [cpuPkg::dataWidth-1:0] siVal,
    output logic [cpuPkg::dataWidth-1:0] diVal
);

    // AX CX DX BX SP BP SI DI
    logic [cpuPkg::dataWidth-1:0] regs [8];

    // Byte index 4..7 is the high half of AX..BX
    always_comb begin
        if (rdWide)
            rdData = regs[rdIdx];
        else if (rdIdx[2])
            rdData = {8'h00, regs[{1'b0, rdIdx[1:0]}][15:8]};
        else
            rdData = {8'h00, regs[rdIdx][7:0]};
    end

    always_ff @(posedge clk25) begin
        if (reset) begin
            for (int n = 0; n < 8; n++)
                regs[n] <= '0;
        end else if (wrEn) begin
            if (wrWide)
                regs[wrIdx] <= wrData;
            else if (wrIdx[2])
                regs[{1'b0, wrIdx[1:0]}][15:8] <= wrData[7:0];   // AH..BH
            else
                regs[wrIdx][7:0] <= wrData[7:0];
        end
    end

    // Address bases for the ModRM logic
    assign bxVal = regs[3];
    assign bpVal = regs[5];
    assign siVal = regs[6];
    assign diVal = regs[7];

    assert property (@(posedge clk25) disable iff (reset) wrEn |-> !$isunknown(wrIdx));

endmodule

// File: logic/sequencer.sv
`timescale 1ns/1ns

module sequencer (
    input  logic                         clk25,
    input  logic                         reset,
    // Memory bus
    input  logic [cpuPkg::byteWidth-1:0] i,
    output logic [cpuPkg::addrWidth-1:0] a,
    output logic [cpuPkg::byteWidth-1:0] o,
    output logic                         w,
    // Decoder
    output cpuPkg::opcodeWord            opcode,
    input  cpuPkg::opClass               cls,
    input  logic [2:0]                   decAluOp,
    input  logic                         decDir,
    input  logic                         decWide,
    input  logic [2:0]                   decRegIdx,
    // Register file
    output logic [2:0]                   rdIdx,
    output logic                         rdWide,
    input  logic [cpuPkg::dataWidth-1:0] rdData,
    output logic                         wrEn,
    output logic [2:0]                   wrIdx,
    output logic                         wrWide,
    output logic [cpuPkg::dataWidth-1:0] wrData,
    input  logic [cpuPkg::dataWidth-1:0] bxVal,
    input  logic [cpuPkg::dataWidth-1:0] bpVal,
    input  logic [cpuPkg::dataWidth-1:0] siVal,
    input  logic [cpuPkg::dataWidth-1:0] diVal,
    // ALU
    output logic [cpuPkg::dataWidth-1:0] op1,
    output logic [cpuPkg::dataWidth-1:0] op2,
    output logic [2:0]                   aluOp,
    output logic                         wide,
    output logic [cpuPkg::flagWidth-1:0] flags,
    output logic [2:0]                   condSel,
    input  logic [cpuPkg::dataWidth-1:0] result,
    input  logic [cpuPkg::flagWidth-1:0] flagsOut,
    input  logic                         condTrue
);

    logic [2:0]                   state;
    logic [2:0]                   step;    // Micro-step inside a phase
    logic [cpuPkg::addrWidth-1:0] ip;
    logic [cpuPkg::addrWidth-1:0] ea;
    logic                         sw;      // Bus address is ea, not ip
    logic [7:0]                   opcodeReg;
    logic [7:0]                   modrm;
    logic [cpuPkg::dataWidth-1:0] res;     // Value being stored
    logic [cpuPkg::addrWidth-1:0] eaBase;
    logic [cpuPkg::dataWidth-1:0] dispSx;
    logic                         toReg;
    logic                         isCmp;

    assign a      = sw ? ea : ip;
    assign w      = (state == cpuPkg::stMemLo) || (state == cpuPkg::stMemHi);
    assign o      = (state == cpuPkg::stMemHi) ? res[15:8] : res[7:0];
    assign opcode = (state == cpuPkg::stFetch) ? i : opcodeReg;

    assign dispSx  = {{8{i[7]}}, i};
    assign toReg   = (modrm[7:6] == 2'b11) || decDir;
    assign isCmp   = decAluOp == cpuPkg::aluCmp;
    assign rdWide  = decWide;
    assign wrWide  = decWide;
    assign aluOp   = decAluOp;
    assign wide    = decWide;
    assign condSel = opcodeReg[3:1];

    // Base of the effective address, from the ModRM byte on the bus
    always_comb begin
        case (i[2:0])
            3'd0: eaBase = bxVal + siVal;
            3'd1: eaBase = bxVal + diVal;
            3'd2: eaBase = bpVal + siVal;
            3'd3: eaBase = bpVal + diVal;
            3'd4: eaBase = siVal;
            3'd5: eaBase = diVal;
            3'd6: eaBase = (i[7:6] == 2'b00) ? '0 : bpVal;   // Direct address
            default: eaBase = bxVal;
        endcase
    end

    // reg field first, rm register one cycle later
    always_comb begin
        rdIdx = cpuPkg::regAx;
        if (state == cpuPkg::stModrm)
            rdIdx = (step == 3'd0) ? i[5:3] : modrm[2:0];
    end

    // Register write-back ----------------------
    always_comb begin
        wrEn   = 1'b0;
        wrIdx  = decRegIdx;
        wrData = result;
        if (state == cpuPkg::stExec) begin
            case (cls)
                cpuPkg::clsAluModrm, cpuPkg::clsMov: begin
                    wrEn  = toReg && !(cls == cpuPkg::clsAluModrm && isCmp);
                    wrIdx = decDir ? modrm[5:3] : modrm[2:0];
                    if (cls == cpuPkg::clsMov)
                        wrData = op2;
                end
                cpuPkg::clsAluImm: wrEn = (step == 3'd2) && !isCmp;
                cpuPkg::clsMovImm: begin
                    wrEn   = !decWide || step == 3'd1;
                    wrData = decWide ? {i, op2[7:0]} : {8'h00, i};
                end
                default: wrEn = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk25) begin
        if (reset) begin
            state <= cpuPkg::stFetch;
            step  <= '0;
            ip    <= cpuPkg::resetIp;
            sw    <= 1'b0;
            flags <= cpuPkg::resetFlags;
        end else begin
            case (state)
                cpuPkg::stFetch: begin
                    opcodeReg <= i;
                    ip        <= ip + 1'b1;
                    step      <= '0;
                    case (cls)
                        cpuPkg::clsAluModrm, cpuPkg::clsMov: state <= cpuPkg::stModrm;
                        cpuPkg::clsFlag: begin
                            if (!i[3])
                                flags[cpuPkg::flagCf] <= ~flags[cpuPkg::flagCf];   // CMC
                            else if (i[2:1] == 2'b00)
                                flags[cpuPkg::flagCf] <= i[0];
                            else if (i[2:1] == 2'b01)
                                flags[cpuPkg::flagIf] <= i[0];
                            else
                                flags[cpuPkg::flagDf] <= i[0];
                        end
                        cpuPkg::clsNop: state <= cpuPkg::stFetch;
                        default: state <= cpuPkg::stExec;
                    endcase
                end

                cpuPkg::stModrm: begin
                    case (step)
                        3'd0: begin
                            modrm <= i;
                            ip    <= ip + 1'b1;
                            ea    <= eaBase;
                            if (decDir) op1 <= rdData; else op2 <= rdData;
                            if (i[7:6] == 2'b11) begin
                                step <= 3'd1;
                            end else if (i[7:6] == 2'b00 && i[2:0] != 3'd6) begin
                                sw   <= 1'b1;
                                step <= 3'd4;
                            end else begin
                                step <= 3'd2;
                            end
                        end
                        3'd1: begin   // rm is a register
                            if (decDir) op2 <= rdData; else op1 <= rdData;
                            state <= cpuPkg::stExec;
                            step  <= '0;
                        end
                        3'd2: begin   // disp8, or low byte of disp16
                            ip <= ip + 1'b1;
                            if (modrm[7:6] == 2'b01) begin
                                ea   <= ea + dispSx;
                                sw   <= 1'b1;
                                step <= 3'd4;
                            end else begin
                                ea   <= ea + {8'h00, i};
                                step <= 3'd3;
                            end
                        end
                        3'd3: begin
                            ea[15:8] <= ea[15:8] + i;
                            ip       <= ip + 1'b1;
                            sw       <= 1'b1;
                            step     <= 3'd4;
                        end
                        3'd4: begin   // Memory operand, low byte
                            if (decDir) op2 <= {8'h00, i}; else op1 <= {8'h00, i};
                            if (decWide) begin
                                ea   <= ea + 1'b1;
                                step <= 3'd5;
                            end else begin
                                state <= cpuPkg::stExec;
                                step  <= '0;
                            end
                        end
                        default: begin
                            if (decDir) op2[15:8] <= i; else op1[15:8] <= i;
                            ea    <= ea - 1'b1;   // Back to the store address
                            state <= cpuPkg::stExec;
                            step  <= '0;
                        end
                    endcase
                end

                cpuPkg::stExec: begin
                    case (cls)
                        cpuPkg::clsAluModrm, cpuPkg::clsMov: begin
                            if (cls == cpuPkg::clsAluModrm)
                                flags <= flagsOut;
                            res <= (cls == cpuPkg::clsMov) ? op2 : result;
                            if (toReg || (cls == cpuPkg::clsAluModrm && isCmp)) begin
                                sw    <= 1'b0;
                                state <= cpuPkg::stFetch;
                            end else begin
                                state <= cpuPkg::stMemLo;
                            end
                        end
                        cpuPkg::clsAluImm: begin
                            if (step == 3'd0) begin
                                op1  <= rdData;
                                op2  <= {8'h00, i};
                                ip   <= ip + 1'b1;
                                step <= decWide ? 3'd1 : 3'd2;
                            end else if (step == 3'd1) begin
                                op2[15:8] <= i;
                                ip        <= ip + 1'b1;
                                step      <= 3'd2;
                            end else begin
                                flags <= flagsOut;
                                state <= cpuPkg::stFetch;
                            end
                        end
                        cpuPkg::clsMovImm: begin
                            op2[7:0] <= i;
                            ip       <= ip + 1'b1;
                            step     <= 3'd1;
                            if (!decWide || step == 3'd1)
                                state <= cpuPkg::stFetch;
                        end
                        cpuPkg::clsJcc, cpuPkg::clsJmp8: begin
                            // Odd Jcc opcodes take the inverted condition
                            if (cls == cpuPkg::clsJmp8 || condTrue != opcodeReg[0])
                                ip <= ip + 1'b1 + dispSx;
                            else
                                ip <= ip + 1'b1;
                            state <= cpuPkg::stFetch;
                        end
                        default: state <= cpuPkg::stFetch;
                    endcase
                end

                cpuPkg::stMemLo: begin
                    if (decWide) begin
                        ea    <= ea + 1'b1;
                        state <= cpuPkg::stMemHi;
                    end else begin
                        sw    <= 1'b0;
                        state <= cpuPkg::stFetch;
                    end
                end

                default: begin   // High byte done
                    sw    <= 1'b0;
                    state <= cpuPkg::stFetch;
                end
            endcase
        end
    end

    // A store is at most two bytes long
    assert property (@(posedge clk25) disable iff (reset) (w && $past(w)) |=> !w);
    assert property (@(posedge clk25) disable iff (reset) state <= cpuPkg::stMemHi);

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then decide from the log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module cpuTb -f flist.f -o cpuSim &&
    ./obj_dir/cpuSim | tee sim.log ||
    { echo "Build or simulation did not run"; exit 1; }
test -f sim.log || { echo "No simulation log"; exit 1; }
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: verif/cpuTb.sv
`timescale 1ns/1ns

module cpuTb;

    logic                         clk25;
    logic                         reset;
    logic [cpuPkg::byteWidth-1:0] i;
    logic [cpuPkg::addrWidth-1:0] a;
    logic [cpuPkg::byteWidth-1:0] o;
    logic                         w;

    logic [cpuPkg::byteWidth-1:0] mem [65536];   // 64 KB memory model
    logic [cpuPkg::addrWidth-1:0] expAddr [$];
    logic [cpuPkg::byteWidth-1:0] expData [$];
    int                           expCount;
    int                           nextIdx;
    int                           byteCount;     // Preloaded bytes, sizes the watchdog
    logic                         loaded;

    cpuTop i_cpuTop (
        .clk25(clk25),
        .reset(reset),
        .i(i),
        .a(a),
        .o(o),
        .w(w)
    );

    initial begin
        clk25 = 1'b0;
        forever #20 clk25 = ~clk25;
    end

    // Reporting ------------------------------
    task automatic stopOnFailure(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic checkAddr(input logic [cpuPkg::addrWidth-1:0] expected,
                             input logic [cpuPkg::addrWidth-1:0] actual);
        string line;
        if (actual !== expected) begin
            line = $sformatf("ERR time=%0t signal=a expected=%h actual=%h",
                             $time, expected, actual);
            stopOnFailure(line);
        end
    endtask

    task automatic checkByte(input logic [cpuPkg::byteWidth-1:0] expected,
                             input logic [cpuPkg::byteWidth-1:0] actual);
        string line;
        if (actual !== expected) begin
            line = $sformatf("ERR time=%0t signal=o expected=%h actual=%h",
                             $time, expected, actual);
            stopOnFailure(line);
        end
    endtask

    // Memory setup ---------------------------
    task automatic fillMemory();
        for (int k = 0; k < 65536; k++)
            mem[k] = 8'(k[15:8] ^ k[7:0] ^ 8'h5c);   // Unique-ish per address
    endtask

    // Tokens: "#" comment line, "M addr" load point, bare hex byte, "W addr byte"
    task automatic loadTrace();
        int                           fd;
        int                           n;
        string                        tok;
        string                        rest;
        logic [cpuPkg::addrWidth-1:0] loadAddr;
        logic [cpuPkg::addrWidth-1:0] wa;
        logic [cpuPkg::byteWidth-1:0] wb;
        logic [cpuPkg::byteWidth-1:0] b;
        loadAddr = '0;
        fd = $fopen("verif/cpuTrace.txt", "r");
        if (fd == 0)
            stopOnFailure("Could not open the trace file verif/cpuTrace.txt");
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                n = $fgets(rest, fd);
            end else if (tok == "M") begin
                n = $fscanf(fd, "%h", loadAddr);
                if (n != 1)
                    stopOnFailure("An M record in the trace file has no address");
            end else if (tok == "W") begin
                n = $fscanf(fd, "%h %h", wa, wb);
                if (n != 2) begin
                    stopOnFailure("A W record in the trace file is incomplete");
                end else begin
                    expAddr.push_back(wa);
                    expData.push_back(wb);
                end
            end else begin
                n = $sscanf(tok, "%h", b);
                if (n != 1) begin
                    stopOnFailure($sformatf("Unreadable token %s in the trace file", tok));
                end else begin
                    mem[loadAddr] = b;
                    loadAddr = loadAddr + 1'b1;   // Wraps past FFFF
                    byteCount++;
                end
            end
        end
        $fclose(fd);
        expCount = expAddr.size();
    endtask

    // Bus side -------------------------------
    task automatic takeWrite();
        if (nextIdx >= expCount) begin
            stopOnFailure($sformatf("Unexpected write of %h to address %h at time %0t",
                                    o, a, $time));
        end else begin
            checkAddr(expAddr[nextIdx], a);
            checkByte(expData[nextIdx], o);
            nextIdx++;
        end
    endtask

    // Store commits here, ahead of the rising edge that ends the write cycle
    always @(negedge clk25) begin
        if (!reset && w === 1'b1) begin
            takeWrite();
            mem[a] = o;
        end
        i <= mem[a];
    end

    initial begin
        wait (loaded === 1'b1);
        #((byteCount * 12 + 200) * 40);
        stopOnFailure("Timeout: the program did not produce all expected writes");
    end

    // Main sequence --------------------------
    initial begin
        reset     = 1'b1;
        i         = '0;
        nextIdx   = 0;
        byteCount = 0;
        expCount  = 0;
        loaded    = 1'b0;
        fillMemory();
        loadTrace();
        loaded = 1'b1;
        if (expCount == 0)
            stopOnFailure("The trace file holds no expected writes");

        repeat (2) @(negedge clk25);
        reset <= 1'b0;

        while (nextIdx < expCount)
            @(negedge clk25);
        repeat (30) @(negedge clk25);   // Catch stray stores after the last one

        $display("All checks passed");
        $finish;
    end

endmodule

// File: verif/cpuTrace.txt
# M addr starts loading at addr, following hex bytes fill upward and wrap past ffff
# W addr byte is the next expected store, in order
# MOV imm, AH aliasing, byte and word stores
M fff0 b8 34 12 b4 ab 89 06 00 20 b1 5a 88 0e 02 20 88 26 03 20
# Eight ALU ops on AL,CL then store AL, CMP last
00 c8 88 06 04 20 08 c8 88 06 05 20 10 c8 88 06 06 20 18 c8 88 06 07 20
20 c8 88 06 08 20 28 c8 88 06 09 20 32 c1 88 06 0a 20 38 c8 88 06 0b 20
# Address bases then [BX+SI], [BP+DI-10h], [1200h], [SI+1300h]
bb 00 10 be 10 00 bf 20 00 bd 00 11 02 00 88 06 0c 20 00 00
8b 43 f0 89 06 0e 20 03 06 00 12 89 06 10 20 21 84 00 13
# Jcc markers after overflow, borrow, zero and odd parity
b0 70 00 c0 b2 01 70 02 b2 02 88 16 12 20
b0 10 b5 20 28 e8 b2 03 73 02 b2 04 88 16 13 20
28 c0 b2 05 74 02 b2 06 88 16 14 20
b0 07 08 c0 b2 07 7a 02 b2 08 88 16 15 20
# STC ADC, CMC SBB, STC CLC ADC
f9 b0 10 b4 20 10 e0 88 06 16 20 f5 18 e0 88 06 17 20 f9 f8 10 e0 88 06 18 20
# Accumulator immediate, JMP over a store, final marker, spin
04 0f 88 06 19 20 35 ff 00 89 06 1a 20 eb 04 88 06 1c 20 b2 aa 88 16 1d 20 eb fe
# Memory operands
M 1010 11
M 1110 22 33
M 1200 01 10
M 1310 0f f0
# Expected stores
W 2000 34
W 2001 ab
W 2002 5a
W 2003 ab
W 2004 8e
W 2005 de
W 2006 38
W 2007 dd
W 2008 58
W 2009 fe
W 200a a4
W 200b a4
W 200c b5
W 1010 c6
W 200e 22
W 200f 33
W 2010 23
W 2011 43
W 1310 03
W 1311 40
W 2012 01
W 2013 04
W 2014 05
W 2015 08
W 2016 31
W 2017 10
W 2018 30
W 2019 3f
W 201a c0
W 201b 20
W 201d aa
